//--- mc_bridge_settings.svh
`ifndef MC_BRIDGE_SETTINGS_SVH
`define MC_BRIDGE_SETTINGS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

`define MCB_ADDR_W 32
`define MCB_DATA_W 32
// tile-local word address
`define MCB_EPA_W 16
`define MCB_X_W 6
`define MCB_Y_W 6

////////////////////////////////////////
// queueing
////////////////////////////////////////

// outstanding network transactions, one id each
`define MCB_MAX_OUT 4
`define MCB_TID_W 2
`define MCB_FIFO_DEPTH 2

////////////////////////////////////////
// address map
////////////////////////////////////////

// dram region, below the manycore global bit
`define MCB_DRAM_BASE 32'h4000_0000
// dram striping across tiles of row 0
`define MCB_TILES_X 4
`define MCB_BLOCK_WORDS 8

`endif

//--- mc_bridge_pkg.sv
`include "mc_bridge_settings.svh"

package mc_bridge_pkg;

  // access size as carried by the processor command
  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2
  } msg_size_e;

  // network request opcodes
  typedef enum logic [1:0]
  {
    e_remote_load         = 2'd0,
    e_remote_store        = 2'd1,
    e_remote_masked_store = 2'd2
  } mc_op_e;

  typedef struct packed
  {
    logic                   write;
    msg_size_e              size;
    logic [`MCB_ADDR_W-1:0] addr;
    logic [`MCB_DATA_W-1:0] data;
  } bridge_cmd_s;

  // header kept per id until the response goes back
  typedef struct packed
  {
    logic                   write;
    msg_size_e              size;
    logic [`MCB_ADDR_W-1:0] addr;
  } bridge_hdr_s;

  // load payload, sits in the low bits of the data field
  typedef struct packed
  {
    logic       is_byte;
    logic       is_half;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed
  {
    logic [`MCB_X_W-1:0]       x;
    logic [`MCB_Y_W-1:0]       y;
    logic [`MCB_X_W-1:0]       src_x;
    logic [`MCB_Y_W-1:0]       src_y;
    logic [`MCB_EPA_W-1:0]     addr;
    mc_op_e                    op;
    logic [`MCB_TID_W-1:0]     reg_id;
    logic [`MCB_DATA_W-1:0]    data;
    logic [`MCB_DATA_W/8-1:0]  mask;
  } mc_packet_s;

  typedef struct packed
  {
    bridge_hdr_s            hdr;
    logic [`MCB_DATA_W-1:0] data;
  } bridge_resp_s;

endpackage

//--- mc_bridge_if.sv
`timescale 1ns/1ps
`include "mc_bridge_settings.svh"

// id allocation handshake between the packet stage and the reorder buffer
interface mc_bridge_if;

  // a free id exists, and which one
  logic                       tid_v;
  logic [`MCB_TID_W-1:0]      tid;

  // take the id and store the header behind it
  logic                       alloc;
  mc_bridge_pkg::bridge_hdr_s hdr;

  modport former
  (
    input  tid_v,
    input  tid,
    output alloc,
    output hdr
  );

  modport rob
  (
    output tid_v,
    output tid,
    input  alloc,
    input  hdr
  );

endinterface

//--- bridge_fifo.sv
`timescale 1ns/1ps
`include "mc_bridge_settings.svh"

module bridge_fifo
  #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = `MCB_FIFO_DEPTH
  )
  (
  input  logic     clk_i,
  input  logic     rst_i,

  input  logic     in_v_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  output logic     out_v_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
  );

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w-1:0] wr_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             push;
  logic             pop;

  // wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign in_ready_o = (count_q != cnt_w'(depth));
  assign out_v_o    = (count_q != '0);
  assign out_data_o = mem[rd_ptr_q];

  assign push = in_v_i & in_ready_o;
  assign pop  = out_v_o & out_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  // storage
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr_q] <= in_data_i;
  end

endmodule

//--- packet_former.sv
`timescale 1ns/1ps
`include "mc_bridge_settings.svh"

module packet_former
  (
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       cmd_v_i,
  output logic                       cmd_ready_o,
  input  mc_bridge_pkg::bridge_cmd_s cmd_i,

  input  logic [`MCB_X_W-1:0]        my_x_i,
  input  logic [`MCB_Y_W-1:0]        my_y_i,

  mc_bridge_if.former                tid,

  output logic                       pkt_v_o,
  input  logic                       pkt_ready_i,
  output mc_bridge_pkg::mc_packet_s  pkt_o
  );

  localparam int mask_w    = `MCB_DATA_W / 8;
  localparam int widx_w    = `MCB_ADDR_W - 2;
  // global address fields, low to high
  localparam int glb_y_lsb = 2 + `MCB_EPA_W;
  localparam int glb_x_lsb = glb_y_lsb + `MCB_Y_W;

  mc_bridge_pkg::mc_packet_s pkt_n;
  mc_bridge_pkg::load_info_s load_info;
  logic [mask_w-1:0]         store_mask;
  logic                      is_global;
  logic                      is_dram;
  logic [widx_w-1:0]         dram_widx;
  logic [widx_w-1:0]         dram_blk;
  logic [widx_w-1:0]         dram_epa;
  logic [`MCB_X_W-1:0]       dram_x;
  logic                      load;

  ////////////////////////////////////////
  // address translation
  ////////////////////////////////////////

  assign is_global = cmd_i.addr[`MCB_ADDR_W-1];
  assign is_dram   = (cmd_i.addr >= `MCB_DRAM_BASE);

  // dram striped in blocks across row 0, column 0 is the host side
  assign dram_widx = cmd_i.addr[`MCB_ADDR_W-1:2];
  assign dram_blk  = dram_widx / `MCB_BLOCK_WORDS;
  assign dram_x    = `MCB_X_W'(1 + (dram_blk % `MCB_TILES_X));
  assign dram_epa  = widx_w'(dram_widx % `MCB_BLOCK_WORDS)
                   + widx_w'((dram_blk / `MCB_TILES_X) * `MCB_BLOCK_WORDS);

  ////////////////////////////////////////
  // store mask and load info
  ////////////////////////////////////////

  always_comb
  begin
    case (cmd_i.size)
      mc_bridge_pkg::e_size_1: store_mask = mask_w'(1) << cmd_i.addr[1:0];
      mc_bridge_pkg::e_size_2: store_mask = mask_w'(3) << cmd_i.addr[1:0];
      default:                 store_mask = {mask_w{1'b1}};
    endcase
  end

  assign load_info.is_byte  = (cmd_i.size == mc_bridge_pkg::e_size_1);
  assign load_info.is_half  = (cmd_i.size == mc_bridge_pkg::e_size_2);
  assign load_info.part_sel = cmd_i.addr[1:0];

  always_comb
  begin
    pkt_n        = '0;
    pkt_n.src_x  = my_x_i;
    pkt_n.src_y  = my_y_i;
    pkt_n.reg_id = tid.tid;

    if (is_global)
    begin
      pkt_n.addr = cmd_i.addr[2 +: `MCB_EPA_W];
      pkt_n.y    = cmd_i.addr[glb_y_lsb +: `MCB_Y_W];
      pkt_n.x    = cmd_i.addr[glb_x_lsb +: `MCB_X_W];
    end
    else if (is_dram)
    begin
      pkt_n.addr = dram_epa[`MCB_EPA_W-1:0];
      pkt_n.y    = '0;
      pkt_n.x    = dram_x;
    end
    else
    begin
      // host sits one row above this node, column 0
      pkt_n.addr = cmd_i.addr[2 +: `MCB_EPA_W];
      pkt_n.y    = my_y_i - `MCB_Y_W'(1);
      pkt_n.x    = '0;
    end

    if (cmd_i.write)
    begin
      pkt_n.op   = (store_mask == {mask_w{1'b1}}) ? mc_bridge_pkg::e_remote_store
                                                  : mc_bridge_pkg::e_remote_masked_store;
      pkt_n.data = cmd_i.data;
      pkt_n.mask = store_mask;
    end
    else
    begin
      pkt_n.op   = mc_bridge_pkg::e_remote_load;
      pkt_n.data = `MCB_DATA_W'(load_info);
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  // load needs a free slot and a free id
  assign cmd_ready_o = (~pkt_v_o | pkt_ready_i) & tid.tid_v;
  assign load        = cmd_v_i & cmd_ready_o;

  assign tid.alloc = load;
  assign tid.hdr   = '{write: cmd_i.write, size: cmd_i.size, addr: cmd_i.addr};

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pkt_v_o <= 1'b0;
    else if (load)
      pkt_v_o <= 1'b1;
    else if (pkt_ready_i)
      pkt_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
      pkt_o <= pkt_n;
  end

endmodule

//--- reorder_buffer.sv
`timescale 1ns/1ps
`include "mc_bridge_settings.svh"

module reorder_buffer
  (
  input  logic                         clk_i,
  input  logic                         rst_i,

  mc_bridge_if.rob                     tid,

  input  logic                         ret_v_i,
  input  logic [`MCB_TID_W-1:0]        ret_reg_id_i,
  input  logic [`MCB_DATA_W-1:0]       ret_data_i,

  output logic                         out_v_o,
  input  logic                         out_ready_i,
  output mc_bridge_pkg::bridge_resp_s  out_o
  );

  localparam int cnt_w = $clog2(`MCB_MAX_OUT + 1);

  mc_bridge_pkg::bridge_hdr_s hdr_mem  [`MCB_MAX_OUT];
  logic [`MCB_DATA_W-1:0]     data_mem [`MCB_MAX_OUT];
  logic [`MCB_MAX_OUT-1:0]    filled_q;
  logic [`MCB_TID_W-1:0]      head_q;
  logic [`MCB_TID_W-1:0]      tail_q;
  logic [cnt_w-1:0]           count_q;
  logic                       release_w;

  function automatic logic [`MCB_TID_W-1:0] ptr_inc(input logic [`MCB_TID_W-1:0] ptr);
    if (ptr == `MCB_TID_W'(`MCB_MAX_OUT - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // id allocation
  ////////////////////////////////////////

  // ids handed out round robin from the tail
  assign tid.tid_v = (count_q != cnt_w'(`MCB_MAX_OUT));
  assign tid.tid   = tail_q;

  ////////////////////////////////////////
  // in-order release
  ////////////////////////////////////////

  // filled implies allocated, so no count check here
  assign out_v_o   = filled_q[head_q];
  assign out_o     = '{hdr: hdr_mem[head_q], data: data_mem[head_q]};
  assign release_w = out_v_o & out_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      head_q   <= '0;
      tail_q   <= '0;
      count_q  <= '0;
      filled_q <= '0;
    end
    else
    begin
      if (tid.alloc)
        tail_q <= ptr_inc(tail_q);
      if (release_w)
        head_q <= ptr_inc(head_q);
      count_q <= count_q + cnt_w'(tid.alloc) - cnt_w'(release_w);

      // a return never targets the head being released this cycle
      if (ret_v_i)
        filled_q[ret_reg_id_i] <= 1'b1;
      if (release_w)
        filled_q[head_q] <= 1'b0;
    end
  end

  // header written at allocation
  always_ff @(posedge clk_i)
  begin
    if (tid.alloc)
      hdr_mem[tail_q] <= tid.hdr;
  end

  // stores answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (ret_v_i)
      data_mem[ret_reg_id_i] <= hdr_mem[ret_reg_id_i].write ? '0 : ret_data_i;
  end

endmodule

//--- mc_bridge.sv
`timescale 1ns/1ps
`include "mc_bridge_settings.svh"

module mc_bridge
  (
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic [`MCB_X_W-1:0]        my_x_i,
  input  logic [`MCB_Y_W-1:0]        my_y_i,

  // processor commands
  input  logic                       cmd_v_i,
  output logic                       cmd_ready_o,
  input  logic                       cmd_write_i,
  input  logic [1:0]                 cmd_size_i,
  input  logic [`MCB_ADDR_W-1:0]     cmd_addr_i,
  input  logic [`MCB_DATA_W-1:0]     cmd_data_i,

  // network request packets
  output logic                       pkt_v_o,
  input  logic                       pkt_ready_i,
  output logic [`MCB_X_W-1:0]        pkt_x_o,
  output logic [`MCB_Y_W-1:0]        pkt_y_o,
  output logic [`MCB_X_W-1:0]        pkt_src_x_o,
  output logic [`MCB_Y_W-1:0]        pkt_src_y_o,
  output logic [`MCB_EPA_W-1:0]      pkt_addr_o,
  output logic [1:0]                 pkt_op_o,
  output logic [`MCB_TID_W-1:0]      pkt_reg_id_o,
  output logic [`MCB_DATA_W-1:0]     pkt_data_o,
  output logic [`MCB_DATA_W/8-1:0]   pkt_mask_o,

  // network returns, always accepted
  input  logic                       ret_v_i,
  input  logic [`MCB_TID_W-1:0]      ret_reg_id_i,
  input  logic [`MCB_DATA_W-1:0]     ret_data_i,

  // responses to the processor
  output logic                       resp_v_o,
  input  logic                       resp_ready_i,
  output logic                       resp_write_o,
  output logic [1:0]                 resp_size_o,
  output logic [`MCB_ADDR_W-1:0]     resp_addr_o,
  output logic [`MCB_DATA_W-1:0]     resp_data_o
  );

  mc_bridge_pkg::bridge_cmd_s  cmd_in;
  mc_bridge_pkg::bridge_cmd_s  cmd_q;
  logic                        cmd_q_v;
  logic                        cmd_q_ready;
  mc_bridge_pkg::mc_packet_s   pkt;
  mc_bridge_pkg::bridge_resp_s rob_resp;
  logic                        rob_v;
  logic                        rob_ready;
  mc_bridge_pkg::bridge_resp_s resp_q;

  mc_bridge_if tid_if ();

  assign cmd_in = '{write: cmd_write_i,
                    size:  mc_bridge_pkg::msg_size_e'(cmd_size_i),
                    addr:  cmd_addr_i,
                    data:  cmd_data_i};

  bridge_fifo
    #(
    .payload_t (mc_bridge_pkg::bridge_cmd_s),
    .depth     (`MCB_FIFO_DEPTH)
    )
    cmd_fifo
    (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_v_i      (cmd_v_i),
    .in_ready_o  (cmd_ready_o),
    .in_data_i   (cmd_in),
    .out_v_o     (cmd_q_v),
    .out_ready_i (cmd_q_ready),
    .out_data_o  (cmd_q)
    );

  packet_former former
    (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_v_i     (cmd_q_v),
    .cmd_ready_o (cmd_q_ready),
    .cmd_i       (cmd_q),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .tid         (tid_if.former),
    .pkt_v_o     (pkt_v_o),
    .pkt_ready_i (pkt_ready_i),
    .pkt_o       (pkt)
    );

  reorder_buffer rob
    (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .tid          (tid_if.rob),
    .ret_v_i      (ret_v_i),
    .ret_reg_id_i (ret_reg_id_i),
    .ret_data_i   (ret_data_i),
    .out_v_o      (rob_v),
    .out_ready_i  (rob_ready),
    .out_o        (rob_resp)
    );

  bridge_fifo
    #(
    .payload_t (mc_bridge_pkg::bridge_resp_s),
    .depth     (`MCB_FIFO_DEPTH)
    )
    resp_fifo
    (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_v_i      (rob_v),
    .in_ready_o  (rob_ready),
    .in_data_i   (rob_resp),
    .out_v_o     (resp_v_o),
    .out_ready_i (resp_ready_i),
    .out_data_o  (resp_q)
    );

  // packet fields out
  assign pkt_x_o      = pkt.x;
  assign pkt_y_o      = pkt.y;
  assign pkt_src_x_o  = pkt.src_x;
  assign pkt_src_y_o  = pkt.src_y;
  assign pkt_addr_o   = pkt.addr;
  assign pkt_op_o     = pkt.op;
  assign pkt_reg_id_o = pkt.reg_id;
  assign pkt_data_o   = pkt.data;
  assign pkt_mask_o   = pkt.mask;

  // response fields out
  assign resp_write_o = resp_q.hdr.write;
  assign resp_size_o  = resp_q.hdr.size;
  assign resp_addr_o  = resp_q.hdr.addr;
  assign resp_data_o  = resp_q.data;

endmodule

//--- mc_bridge_tb.sv
`timescale 1ns/1ps
`include "mc_bridge_settings.svh"

module mc_bridge_tb;

  localparam int num_cmds      = 60;
  localparam int rst_cycles    = 5;
  localparam int max_cycles    = num_cmds * 40;
  // response side stalls during every third window of this length
  localparam int stall_period  = 60;
  localparam logic [31:0] ret_xor = 32'hA5A5_0000;

  logic                        clk_i        = 1'b0;
  logic                        rst_i        = 1'b1;
  logic [`MCB_X_W-1:0]         my_x_i       = 6'd3;
  logic [`MCB_Y_W-1:0]         my_y_i       = 6'd5;
  logic                        cmd_v_i      = 1'b0;
  logic                        cmd_write_i  = 1'b0;
  logic [1:0]                  cmd_size_i   = 2'd0;
  logic [`MCB_ADDR_W-1:0]      cmd_addr_i   = '0;
  logic [`MCB_DATA_W-1:0]      cmd_data_i   = '0;
  logic                        pkt_ready_i  = 1'b0;
  logic                        ret_v_i      = 1'b0;
  logic [`MCB_TID_W-1:0]       ret_reg_id_i = '0;
  logic [`MCB_DATA_W-1:0]      ret_data_i   = '0;
  logic                        resp_ready_i = 1'b0;

  logic                        cmd_ready_o;
  logic                        pkt_v_o;
  logic [`MCB_X_W-1:0]         pkt_x_o;
  logic [`MCB_Y_W-1:0]         pkt_y_o;
  logic [`MCB_X_W-1:0]         pkt_src_x_o;
  logic [`MCB_Y_W-1:0]         pkt_src_y_o;
  logic [`MCB_EPA_W-1:0]       pkt_addr_o;
  logic [1:0]                  pkt_op_o;
  logic [`MCB_TID_W-1:0]       pkt_reg_id_o;
  logic [`MCB_DATA_W-1:0]      pkt_data_o;
  logic [`MCB_DATA_W/8-1:0]    pkt_mask_o;
  logic                        resp_v_o;
  logic                        resp_write_o;
  logic [1:0]                  resp_size_o;
  logic [`MCB_ADDR_W-1:0]      resp_addr_o;
  logic [`MCB_DATA_W-1:0]      resp_data_o;
  logic [79:0]                 pkt_bus;

  integer                      seed = 83;
  int                          cycle = 0;
  logic                        run_done = 1'b0;
  int                          mismatch_count = 0;
  int                          other_count = 0;
  int                          stall_count = 0;

  // command set and reference model
  logic                        cmd_write_a [num_cmds];
  logic [1:0]                  cmd_size_a  [num_cmds];
  logic [31:0]                 cmd_addr_a  [num_cmds];
  logic [31:0]                 cmd_data_a  [num_cmds];
  int                          cmd_idx = 0;
  logic                        cmd_taken = 1'b0;
  int                          pkt_exp_q [$];
  int                          resp_exp_q [$];
  int                          pkt_sent = 0;
  int                          returns_given = 0;
  int                          resp_count = 0;

  // network model, packets waiting for their return
  logic [`MCB_MAX_OUT-1:0]     in_flight = '0;
  logic [`MCB_TID_W-1:0]       pool_id [$];
  logic [31:0]                 pool_data [$];
  int                          pool_due [$];

  always #5 clk_i = ~clk_i;

  mc_bridge DUT
    (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .my_x_i       (my_x_i),
    .my_y_i       (my_y_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_write_i  (cmd_write_i),
    .cmd_size_i   (cmd_size_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .pkt_v_o      (pkt_v_o),
    .pkt_ready_i  (pkt_ready_i),
    .pkt_x_o      (pkt_x_o),
    .pkt_y_o      (pkt_y_o),
    .pkt_src_x_o  (pkt_src_x_o),
    .pkt_src_y_o  (pkt_src_y_o),
    .pkt_addr_o   (pkt_addr_o),
    .pkt_op_o     (pkt_op_o),
    .pkt_reg_id_o (pkt_reg_id_o),
    .pkt_data_o   (pkt_data_o),
    .pkt_mask_o   (pkt_mask_o),
    .ret_v_i      (ret_v_i),
    .ret_reg_id_i (ret_reg_id_i),
    .ret_data_i   (ret_data_i),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i),
    .resp_write_o (resp_write_o),
    .resp_size_o  (resp_size_o),
    .resp_addr_o  (resp_addr_o),
    .resp_data_o  (resp_data_o)
    );

  assign pkt_bus = {pkt_x_o, pkt_y_o, pkt_src_x_o, pkt_src_y_o, pkt_addr_o,
                    pkt_op_o, pkt_reg_id_o, pkt_data_o, pkt_mask_o};

  // a refused packet stays offered and unchanged
  assert property (@(posedge clk_i) disable iff (rst_i)
    (pkt_v_o && !pkt_ready_i) |=> (pkt_v_o && $stable(pkt_bus)))
  else
  begin
    $display("stalled packet was dropped or changed before acceptance at %0t", $time);
    stall_count++;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    assert (got === expected)
    else
    begin
      $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
      mismatch_count++;
    end
  endtask

  // one command per region pick, aligned to its size
  task automatic generate_commands();
    int          size;
    logic [31:0] addr;
    for (int i = 0; i < num_cmds; i++)
    begin
      addr = $random(seed);
      case (rand_below(3))
        0:       addr[31]    = 1'b1;
        1:       addr[31:30] = 2'b01;
        default: addr[31:30] = 2'b00;
      endcase
      size = rand_below(3);
      if (size == 1)
        addr[0] = 1'b0;
      if (size == 2)
        addr[1:0] = 2'b00;
      cmd_write_a[i] = (rand_below(2) == 1);
      cmd_size_a[i]  = 2'(size);
      cmd_addr_a[i]  = addr;
      cmd_data_a[i]  = $random(seed);
    end
  endtask

  // destination tile and word address of the three regions
  task automatic route_address(input logic [31:0] addr, output logic [5:0] x,
                               output logic [5:0] y, output logic [15:0] epa);
    logic [31:0] widx;
    logic [31:0] blk;
    logic [31:0] local_word;
    widx = addr >> 2;
    blk  = widx / `MCB_BLOCK_WORDS;
    if (addr[31])
    begin
      x   = addr[29:24];
      y   = addr[23:18];
      epa = addr[17:2];
    end
    else if (addr >= `MCB_DRAM_BASE)
    begin
      x          = 6'(1 + blk % `MCB_TILES_X);
      y          = '0;
      local_word = widx % `MCB_BLOCK_WORDS + (blk / `MCB_TILES_X) * `MCB_BLOCK_WORDS;
      epa        = local_word[15:0];
    end
    else
    begin
      x   = '0;
      y   = my_y_i - 6'd1;
      epa = addr[17:2];
    end
  endtask

  task automatic check_packet();
    int          idx;
    logic [5:0]  ex;
    logic [5:0]  ey;
    logic [15:0] ea;
    logic [3:0]  mask;
    logic [31:0] info;
    if (pkt_exp_q.size() == 0)
    begin
      $display("packet sent at %0t with no command waiting for it", $time);
      other_count++;
      return;
    end
    idx = pkt_exp_q.pop_front();
    route_address(cmd_addr_a[idx], ex, ey, ea);
    compare_field("pkt_x_o", 32'(pkt_x_o), 32'(ex));
    compare_field("pkt_y_o", 32'(pkt_y_o), 32'(ey));
    compare_field("pkt_addr_o", 32'(pkt_addr_o), 32'(ea));
    compare_field("pkt_src_x_o", 32'(pkt_src_x_o), 32'(my_x_i));
    compare_field("pkt_src_y_o", 32'(pkt_src_y_o), 32'(my_y_i));
    if (cmd_write_a[idx])
    begin
      case (cmd_size_a[idx])
        2'd0:    mask = 4'b0001 << cmd_addr_a[idx][1:0];
        2'd1:    mask = 4'b0011 << cmd_addr_a[idx][1:0];
        default: mask = 4'b1111;
      endcase
      compare_field("pkt_mask_o", 32'(pkt_mask_o), 32'(mask));
      compare_field("pkt_op_o", 32'(pkt_op_o), (mask == 4'b1111) ? 32'd1 : 32'd2);
      compare_field("pkt_data_o", pkt_data_o, cmd_data_a[idx]);
    end
    else
    begin
      info = {28'd0, cmd_size_a[idx] == 2'd0, cmd_size_a[idx] == 2'd1, cmd_addr_a[idx][1:0]};
      compare_field("pkt_op_o", 32'(pkt_op_o), 32'd0);
      compare_field("pkt_data_o", pkt_data_o, info);
    end
    resp_exp_q.push_back(idx);
  endtask

  task automatic check_response();
    int          idx;
    logic [5:0]  ex;
    logic [5:0]  ey;
    logic [15:0] ea;
    logic [31:0] data;
    if (resp_exp_q.size() == 0)
    begin
      $display("response at %0t with no packet issued for it", $time);
      other_count++;
      return;
    end
    idx = resp_exp_q.pop_front();
    route_address(cmd_addr_a[idx], ex, ey, ea);
    // loads get the network data back, stores get zero
    data = cmd_write_a[idx] ? 32'd0 : ({16'd0, ea} ^ ret_xor);
    compare_field("resp_write_o", 32'(resp_write_o), 32'(cmd_write_a[idx]));
    compare_field("resp_size_o", 32'(resp_size_o), 32'(cmd_size_a[idx]));
    compare_field("resp_addr_o", resp_addr_o, cmd_addr_a[idx]);
    compare_field("resp_data_o", resp_data_o, data);
    resp_count++;
  endtask

  task automatic drive_command();
    if (cmd_v_i && !cmd_taken)
      return;
    cmd_taken = 1'b0;
    cmd_v_i   = (cmd_idx < num_cmds) && (rand_below(4) != 0);
    if (cmd_v_i)
    begin
      cmd_write_i = cmd_write_a[cmd_idx];
      cmd_size_i  = cmd_size_a[cmd_idx];
      cmd_addr_i  = cmd_addr_a[cmd_idx];
      cmd_data_i  = cmd_data_a[cmd_idx];
    end
  endtask

  // random ready, returns picked at random from the pool once due
  task automatic drive_network();
    int k;
    pkt_ready_i  = (rand_below(4) != 0);
    resp_ready_i = ((cycle / stall_period) % 3 == 1) ? 1'b0 : (rand_below(2) == 1);
    ret_v_i      = 1'b0;
    if (pool_id.size() > 0 && rand_below(2) == 0)
    begin
      k = rand_below(pool_id.size());
      if (pool_due[k] <= cycle)
      begin
        ret_v_i               = 1'b1;
        ret_reg_id_i          = pool_id[k];
        ret_data_i            = pool_data[k];
        in_flight[pool_id[k]] = 1'b0;
        returns_given++;
        pool_id.delete(k);
        pool_data.delete(k);
        pool_due.delete(k);
      end
    end
  endtask

  ////////////////////////////////////////
  // sample before the edge, drive after
  ////////////////////////////////////////

  always @(posedge clk_i)
  begin
    cycle++;
    if (cycle == 1)
      generate_commands();
    if (cycle == rst_cycles + 1)
    begin
      compare_field("pkt_v_o", 32'(pkt_v_o), 32'd0);
      compare_field("resp_v_o", 32'(resp_v_o), 32'd0);
      compare_field("cmd_ready_o", 32'(cmd_ready_o), 32'd1);
    end
    if (cycle > rst_cycles + 1)
    begin
      // all ids held by undelivered responses
      if (pkt_sent - resp_count >= `MCB_MAX_OUT + `MCB_FIFO_DEPTH)
      begin
        assert (!pkt_v_o)
        else
        begin
          $display("packet offered at %0t while every id is held by a stalled response",
                   $time);
          other_count++;
        end
      end
      if (cmd_v_i && cmd_ready_o)
      begin
        pkt_exp_q.push_back(cmd_idx);
        cmd_idx++;
        cmd_taken = 1'b1;
      end
      if (pkt_v_o && pkt_ready_i)
      begin
        check_packet();
        assert (!in_flight[pkt_reg_id_o])
        else
        begin
          $display("register id %0d reused while still in flight at %0t", pkt_reg_id_o, $time);
          other_count++;
        end
        in_flight[pkt_reg_id_o] = 1'b1;
        pool_id.push_back(pkt_reg_id_o);
        pool_data.push_back(32'(pkt_addr_o) ^ ret_xor);
        pool_due.push_back(cycle + 1 + rand_below(12));
        pkt_sent++;
        assert (pkt_sent - returns_given <= `MCB_MAX_OUT)
        else
        begin
          $display("more than %0d packets outstanding at %0t", `MCB_MAX_OUT, $time);
          other_count++;
        end
      end
      if (resp_v_o && resp_ready_i)
        check_response();
    end
    if (!run_done && (resp_count == num_cmds || cycle >= max_cycles))
    begin
      if (resp_count != num_cmds)
      begin
        $display("timeout after %0d cycles with %0d of %0d responses", cycle, resp_count,
                 num_cmds);
        other_count++;
      end
      run_done = 1'b1;
    end
    #1;
    if (cycle == rst_cycles)
      rst_i = 1'b0;
    if (cycle > rst_cycles)
    begin
      drive_command();
      drive_network();
    end
  end

  initial
  begin
    wait (run_done);
    $display("errors: %0d mismatches, %0d other failures, %0d stall failures",
             mismatch_count, other_count, stall_count);
    if (mismatch_count + other_count + stall_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- mc_bridge.f
+incdir+.
mc_bridge_pkg.sv
mc_bridge_if.sv
bridge_fifo.sv
packet_former.sv
reorder_buffer.sv
mc_bridge.sv
mc_bridge_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mc_bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mc_bridge.f \
  --top-module mc_bridge_tb -o mc_bridge_sim

out=$(./obj_dir/mc_bridge_sim)
echo "$out"

if grep -q "STATUS: PASS" <<< "$out"; then
  exit 0
else
  exit 1
fi
